// ==== bench/iwrr_tests.txt ====
# Columns in hex: cfg_en cfg_agent cfg_weight request expected_grant
# One line per cycle, the grant is the one seen in the cycle after the line
# Default weights of 1, all agents requesting
0 0 0 f 1
0 0 0 f 2
0 0 0 f 4
0 0 0 f 8
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
# Rotation carries on after the reload, then agent 0 gets 3 and agent 1 gets 1
0 0 0 f 1
0 0 0 f 2
0 0 0 f 4
0 0 0 f 8
1 0 3 0 0
1 1 1 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
# Agents 0 and 1 share one window, agent 2 is set to weight 0
0 0 0 3 1
0 0 0 3 2
0 0 0 3 1
0 0 0 3 1
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
1 2 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
0 0 0 3 0
# Agent 2 blocked while others are served, then alone; agent 3 set to weight 2
0 0 0 f 2
0 0 0 f 8
0 0 0 f 1
0 0 0 f 1
0 0 0 f 1
0 0 0 f 0
0 0 0 f 0
0 0 0 f 0
1 3 2 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
# Agent 2 alone after a reload, then agent 3 alone with weight 2
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 4 0
0 0 0 8 8
0 0 0 8 8
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
# Weight 4 for agent 3 written mid-window, the count changes only after the reload
0 0 0 8 8
0 0 0 8 8
0 0 0 8 0
0 0 0 8 0
1 3 4 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 0
0 0 0 8 8
0 0 0 8 8
0 0 0 8 8
0 0 0 8 8
0 0 0 8 0

// ==== sim.f ====
+incdir+hdl
hdl/iwrr_pkg.sv
hdl/iwrr_weight_regs.sv
hdl/iwrr_credit_tracker.sv
hdl/iwrr_grant_select.sv
hdl/iwrr_arbiter_top.sv
bench/iwrr_properties.sv
bench/iwrr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the arbiter testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -f sim.f --top-module iwrr_tb -o iwrr_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/iwrr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
grep -q '>>> FAIL' "$LOG" && { echo "Test failed, see $LOG"; exit 1; }
[ "$status" -eq 0 ] || { echo "Simulator exited with status $status"; exit 1; }
echo "Test passed"

// ==== bench/iwrr_tb.sv ====
`timescale 1ns/1ps

module iwrr_tb;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 8;
    localparam string TEST_FILE    = "bench/iwrr_tests.txt";

    // One line of the test file, as it is applied to the DUT
    typedef struct packed {
        iwrr_pkg::cfg_write_t  cfg;
        iwrr_pkg::agent_mask_t request;
        iwrr_pkg::agent_mask_t exp_grant;
    } vector_t;

    logic                  clk;
    logic                  rst_n;
    iwrr_pkg::cfg_write_t  cfg;
    iwrr_pkg::agent_mask_t request;
    iwrr_pkg::agent_mask_t grant;

    vector_t vectors[$];
    int      n_checks;
    int      n_errors;
    bit      loaded;

    iwrr_arbiter_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .request (request),
        .grant   (grant)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Lines starting with # are comments, every other line is one cycle
    task automatic load_vectors(output bit ok);
        int      fd;
        int      line_no;
        int      n_fields;
        int      en;
        int      agent;
        int      weight;
        int      req;
        int      exp;
        string   line;
        vector_t v;

        ok = 1'b0;
        line_no = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %h %h %h %h", en, agent, weight, req, exp);
            if (n_fields != 5) begin
                $display("Test file ends early: line %0d holds %0d of 5 fields",
                         line_no, n_fields);
                $fclose(fd);
                return;
            end
            v.cfg.en     = (en != 0);
            v.cfg.agent  = iwrr_pkg::agent_idx_t'(agent);
            v.cfg.weight = iwrr_pkg::weight_t'(weight);
            v.request    = iwrr_pkg::agent_mask_t'(req);
            v.exp_grant  = iwrr_pkg::agent_mask_t'(exp);
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The test file holds no vectors");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic check_grant(input int idx, input iwrr_pkg::agent_mask_t exp_grant);
        n_checks++;
        assert (grant === exp_grant) else begin
            $display("MISMATCH grant at vector %0d: expected %h, actual %h",
                     idx, exp_grant, grant);
            n_errors++;
        end
    endtask

    initial begin : main
        bit ok;

        cfg      = '0;
        request  = '0;
        rst_n    = 1'b0;
        n_checks = 0;
        n_errors = 0;
        load_vectors(ok);
        if (!ok) begin
            n_errors++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Each vector is driven on a falling edge, its grant appears after
        // the next rising edge and is checked on the falling edge after that
        if (ok) begin
            for (int i = 0; i < vectors.size(); i++) begin
                cfg     = vectors[i].cfg;
                request = vectors[i].request;
                @(negedge clk);
                check_grant(i, vectors[i].exp_grant);
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Reset plus one cycle per vector fits well inside this margin
    initial begin : watchdog
        wait (loaded);
        #((vectors.size() + 20) * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", vectors.size() + 20);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== bench/iwrr_properties.sv ====
`timescale 1ns/1ps

module iwrr_arbiter_props (
    input logic                  clk,
    input logic                  rst_n,
    input iwrr_pkg::agent_mask_t request,
    input iwrr_pkg::agent_mask_t grant
);

    // Never more than one agent owns the bus
    grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(grant)
    ) else $error("grant has more than one bit set: %h", grant);

    // The grant seen at an edge was picked from the request of the edge before
    grant_requested: assert property (
        @(posedge clk) disable iff (!rst_n) (grant & ~$past(request)) == '0
    ) else $error("grant %h went to an agent that was not requesting", grant);

    grant_idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> grant == '0
    ) else $error("grant is %h in the first cycle after reset", grant);

endmodule

bind iwrr_arbiter_top iwrr_arbiter_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (request),
    .grant   (grant)
);

// ==== hdl/iwrr_arbiter_top.sv ====
`timescale 1ns/1ps

`include "iwrr_cfg.svh"

module iwrr_arbiter_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  iwrr_pkg::cfg_write_t  cfg,
    input  iwrr_pkg::agent_mask_t request,
    output iwrr_pkg::agent_mask_t grant
);

    iwrr_pkg::weight_vec_t weights;
    iwrr_pkg::agent_mask_t eligible;
    iwrr_pkg::agent_mask_t pick;

    // Programmed weights, applied by the tracker at each window reload
    iwrr_weight_regs u_weight_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .weights (weights)
    );

    // Credits per window and the resulting eligibility mask
    iwrr_credit_tracker u_credit_tracker (
        .clk      (clk),
        .rst_n    (rst_n),
        .weights  (weights),
        .request  (request),
        .pick     (pick),
        .eligible (eligible)
    );

    // The pick goes back to the tracker and is charged on the same
    // edge that turns it into the grant
    iwrr_grant_select u_grant_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .eligible (eligible),
        .pick     (pick),
        .grant    (grant)
    );

endmodule

// ==== hdl/iwrr_grant_select.sv ====
`timescale 1ns/1ps

`include "iwrr_cfg.svh"

module iwrr_grant_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  iwrr_pkg::agent_mask_t eligible,
    output iwrr_pkg::agent_mask_t pick,
    output iwrr_pkg::agent_mask_t grant
);

    // Agent that has first claim on the next grant
    iwrr_pkg::agent_idx_t ptr;

    // Index of the agent that the search found when pick is non-zero
    iwrr_pkg::agent_idx_t win_idx;

    // Walk upward from the pointer and take the first eligible agent.
    // The index is as wide as an agent number, so the walk wraps by itself
    always_comb begin
        iwrr_pkg::agent_idx_t idx;
        logic                 found;

        pick    = '0;
        win_idx = ptr;
        found   = 1'b0;
        for (int off = 0; off < `IWRR_NUM_AGENTS; off++) begin
            idx = ptr + iwrr_pkg::agent_idx_t'(off);
            if (!found && eligible[idx]) begin
                found        = 1'b1;
                pick[idx]    = 1'b1;
                win_idx      = idx;
            end
        end
    end

    // Grant is the pick delayed by one edge, so a request seen at one edge
    // shows up as a one-cycle grant pulse right after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= pick;
        end
    end

    // The pointer moves just past the winner, the winner goes to the back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|pick) begin
            ptr <= win_idx + 1'b1;
        end
    end

endmodule

// ==== hdl/iwrr_credit_tracker.sv ====
`timescale 1ns/1ps

`include "iwrr_cfg.svh"

module iwrr_credit_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  iwrr_pkg::weight_vec_t weights,
    input  iwrr_pkg::agent_mask_t request,
    input  iwrr_pkg::agent_mask_t pick,
    output iwrr_pkg::agent_mask_t eligible
);

    iwrr_pkg::window_cnt_t win_cnt;
    logic                  window_end;

    // Credit left to each agent in the running window
    iwrr_pkg::weight_t credit [`IWRR_NUM_AGENTS];

    assign window_end = (win_cnt == iwrr_pkg::window_cnt_t'(`IWRR_WINDOW_CYCLES - 1));

    // Free-running window counter, starts from 0 when reset is released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else if (window_end) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // At window end every credit is refilled from its weight.
    // The refill wins over a grant taken on the same edge; that grant
    // is charged to the old window, which is ending anyway
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `IWRR_NUM_AGENTS; i++) begin
                credit[i] <= iwrr_pkg::weight_t'(`IWRR_DEFAULT_WEIGHT);
            end
        end else begin
            for (int i = 0; i < `IWRR_NUM_AGENTS; i++) begin
                if (window_end) begin
                    credit[i] <= weights[i*`IWRR_WEIGHT_WIDTH +: `IWRR_WEIGHT_WIDTH];
                end else if (pick[i]) begin
                    // Pick only ever selects an eligible agent, so credit is non-zero here
                    credit[i] <= credit[i] - 1'b1;
                end
            end
        end
    end

    // An agent may compete only while it requests and still has credit.
    // Agents out of credit wait for the reload even if nobody else asks
    always_comb begin
        for (int i = 0; i < `IWRR_NUM_AGENTS; i++) begin
            eligible[i] = request[i] && (credit[i] != '0);
        end
    end

endmodule

// ==== hdl/iwrr_weight_regs.sv ====
`timescale 1ns/1ps

`include "iwrr_cfg.svh"

module iwrr_weight_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  iwrr_pkg::cfg_write_t  cfg,
    output iwrr_pkg::weight_vec_t weights
);

    // One stored weight per agent
    iwrr_pkg::weight_t weight_q [`IWRR_NUM_AGENTS];

    // Every agent starts at the default weight so that the arbiter
    // serves everyone out of reset without any configuration
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `IWRR_NUM_AGENTS; i++) begin
                weight_q[i] <= iwrr_pkg::weight_t'(`IWRR_DEFAULT_WEIGHT);
            end
        end else if (cfg.en) begin
            weight_q[cfg.agent] <= cfg.weight;
        end
    end

    // Flatten the bank for the credit tracker
    genvar g;
    generate
        for (g = 0; g < `IWRR_NUM_AGENTS; g++) begin : g_pack
            assign weights[g*`IWRR_WEIGHT_WIDTH +: `IWRR_WEIGHT_WIDTH] = weight_q[g];
        end
    endgenerate

endmodule

// ==== hdl/iwrr_pkg.sv ====
`include "iwrr_cfg.svh"

package iwrr_pkg;

    // One bit per agent with agent 0 in bit 0
    typedef logic [`IWRR_NUM_AGENTS-1:0] agent_mask_t;

    // Agent number
    typedef logic [`IWRR_AGENT_IDX_WIDTH-1:0] agent_idx_t;

    // A single weight, or the credit left to one agent
    typedef logic [`IWRR_WEIGHT_WIDTH-1:0] weight_t;

    // All weights side by side with agent 0 in the low bits
    typedef logic [`IWRR_NUM_AGENTS*`IWRR_WEIGHT_WIDTH-1:0] weight_vec_t;

    // Cycle position inside the current window
    typedef logic [`IWRR_WINDOW_CNT_WIDTH-1:0] window_cnt_t;

    // Weight write strobe
    // The write happens only in a cycle where en is high
    typedef struct packed {
        logic       en;
        agent_idx_t agent;
        weight_t    weight;
    } cfg_write_t;

endpackage

// ==== hdl/iwrr_cfg.svh ====
`ifndef IWRR_CFG_SVH
`define IWRR_CFG_SVH

// Number of requesting agents on the arbiter
`define IWRR_NUM_AGENTS 4

// Bits of a weight and of each credit counter
`define IWRR_WEIGHT_WIDTH 4

// Credits reload once per window of this many clock cycles
`define IWRR_WINDOW_CYCLES 16

// Weight of every agent after reset
`define IWRR_DEFAULT_WEIGHT 1

// Derived widths
`define IWRR_AGENT_IDX_WIDTH $clog2(`IWRR_NUM_AGENTS)
`define IWRR_WINDOW_CNT_WIDTH $clog2(`IWRR_WINDOW_CYCLES)

`endif
